// File: list.f
rtl/chess_pkg.sv
rtl/eval_pkg.sv
rtl/eval_term_if.sv
rtl/popcount.sv
rtl/evaluate_material.sv
rtl/evaluate_pawns.sv
rtl/evaluate.sv
verification/evaluate_tb.sv

// File: rtl/chess_pkg.sv
package chess_pkg;

   localparam int PIECE_WIDTH = 4;
   localparam int SQUARE_COUNT = 64;
   localparam int BOARD_WIDTH = PIECE_WIDTH * SQUARE_COUNT;

   // Bit 3 of a square is colour and bits 2:0 the piece type
   typedef logic [PIECE_WIDTH - 1:0] piece_t;

   typedef logic [2:0] piece_type_t;

   // Square s = file + 8 * rank sits at bits 4s+3 down to 4s
   typedef logic [BOARD_WIDTH - 1:0] board_t;

   typedef logic [SQUARE_COUNT - 1:0] square_mask_t;

   localparam piece_t EMPTY_POSN = 4'b0000;
   localparam piece_t BLACK_BIT = 4'b1000;

   // Piece types shared by both colours
   // Type 6 is the king, which carries no material value
   localparam piece_type_t PAWN = 3'd1;
   localparam piece_type_t KNIGHT = 3'd2;
   localparam piece_type_t BISHOP = 3'd3;
   localparam piece_type_t ROOK = 3'd4;
   localparam piece_type_t QUEEN = 3'd5;

endpackage

// File: rtl/eval_pkg.sv
package eval_pkg;

   localparam int EVAL_WIDTH = 16;

   // Signed score from white's view
   typedef logic signed [EVAL_WIDTH - 1:0] eval_t;

   // Blend products need headroom for phase and scale factors
   localparam int SCORE_WIDTH = 48;
   typedef logic signed [SCORE_WIDTH - 1:0] score_t;

   // Phase is the capped occupied square count
   typedef logic [6:0] phase_t;

   // Indexed by piece type in the order empty, P, N, B, R, Q, K, unused
   localparam int PIECE_MG [8] = '{0, 82, 337, 365, 477, 1025, 0, 0};
   localparam int PIECE_EG [8] = '{0, 94, 281, 297, 512, 936, 0, 0};

   // Per extra pawn on a file
   localparam int DOUBLED_MG = 11;
   localparam int DOUBLED_EG = 56;

   // Per pawn with no friendly pawn on either neighbour file
   localparam int ISOLATED_MG = 5;
   localparam int ISOLATED_EG = 15;

   localparam phase_t PHASE_MAX = 7'd62;

   // Division by PHASE_MAX done as multiply then shift-sized divide
   localparam int PHASE_SCALE = 16912;      // 1048576 / 62
   localparam int PHASE_SHIFT_DIV = 1048576;

   // Cycles for the blend pipeline to settle after both terms are valid
   localparam int LATENCY_COUNT = 6;

   typedef enum logic [1:0]
   {
      idle,
      wait_eval,
      wait_latency,
      wait_clear
   } eval_state_t;

endpackage

// File: rtl/eval_term_if.sv
interface eval_term_if
   import chess_pkg::*, eval_pkg::*;
();

   logic   start;    // High while the board is frozen
   board_t board;
   eval_t  mg;
   eval_t  eg;
   logic   valid;    // Held until start falls

   modport evaluator
   (
      input  start, board,
      output mg, eg, valid
   );

   modport collector
   (
      output start, board,
      input  mg, eg, valid
   );

endinterface

// File: rtl/evaluate.sv
module evaluate
   import chess_pkg::*, eval_pkg::*;
(
   input  logic               clk,
   input  logic               reset,
   input  logic               board_valid,
   input  board_t             board_in,
   input  logic               clear_eval,
   output eval_t              eval,
   output logic               eval_valid,
   output logic signed [31:0] material,
   output logic               insufficient_material
);

   eval_state_t  state;
   logic         board_valid_r;
   logic         board_edge;
   board_t       board;
   logic         start;
   logic [2:0]   latency;
   square_mask_t occupied;
   logic [6:0]   occupied_count;
   phase_t       phase;
   score_t       mg_t1, eg_t1;
   score_t       mg_t2, eg_t2;
   score_t       score_t3, score_t4, score_t5;

   eval_term_if material_term ();
   eval_term_if pawn_term ();

   assign material_term.start = start;
   assign material_term.board = board;
   assign pawn_term.start = start;
   assign pawn_term.board = board;

   // Previous board_valid for rising edge detection
   always_ff @(posedge clk)
      board_valid_r <= board_valid;

   assign board_edge = board_valid && !board_valid_r;

   // Board follows the input in idle and is frozen otherwise
   always_ff @(posedge clk)
   begin
      if (state == idle)
         board <= board_in;
   end

   always_comb
   begin
      for (int s = 0; s < SQUARE_COUNT; s++)
         occupied[s] = board[s * PIECE_WIDTH +: PIECE_WIDTH] != EMPTY_POSN;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= idle;
         start <= 1'b0;
         latency <= '0;
      end
      else
      begin
         case (state)
            idle:
            begin
               latency <= '0;
               if (board_edge)
               begin
                  state <= wait_eval;
                  start <= 1'b1;
               end
            end
            wait_eval:
               if (material_term.valid && pawn_term.valid)
                  state <= wait_latency;
            wait_latency:
            begin
               latency <= latency + 3'd1;
               if (latency == 3'(LATENCY_COUNT - 1))
                  state <= wait_clear;
            end
            wait_clear:
               if (clear_eval)
               begin
                  state <= idle;
                  start <= 1'b0;
               end
            default:
               state <= idle;
         endcase
      end
   end

   // Lags the state by one cycle and so also covers the cycle after clear
   always_ff @(posedge clk)
   begin
      if (reset)
         eval_valid <= 1'b0;
      else
         eval_valid <= (state == wait_clear);
   end

   // Free-running phase blend
   always_ff @(posedge clk)
   begin
      phase <= (occupied_count > PHASE_MAX) ? PHASE_MAX : occupied_count;
      mg_t1 <= score_t'(material_term.mg) + score_t'(pawn_term.mg);
      eg_t1 <= score_t'(material_term.eg) + score_t'(pawn_term.eg);
      mg_t2 <= mg_t1 * score_t'(phase);
      eg_t2 <= eg_t1 * (score_t'(PHASE_MAX) - score_t'(phase));
      score_t3 <= mg_t2 + eg_t2;
      score_t4 <= score_t3 * score_t'(PHASE_SCALE);
      score_t5 <= score_t4 / score_t'(PHASE_SHIFT_DIV);   // Truncates toward zero
      eval <= eval_t'(score_t5);
   end

   popcount popcount_occupied
   (
      .clk        (clk),
      .reset      (reset),
      .x0         (occupied),
      .population (occupied_count)
   );

   evaluate_material evaluate_material
   (
      .clk                   (clk),
      .reset                 (reset),
      .term                  (material_term.evaluator),
      .material              (material),
      .insufficient_material (insufficient_material)
   );

   evaluate_pawns evaluate_pawns
   (
      .clk   (clk),
      .reset (reset),
      .term  (pawn_term.evaluator)
   );

endmodule

// File: rtl/evaluate_material.sv
module evaluate_material
   import chess_pkg::*, eval_pkg::*;
(
   input  logic               clk,
   input  logic               reset,
   eval_term_if.evaluator     term,
   output logic signed [31:0] material,
   output logic               insufficient_material
);

   int   mg_sum;
   int   eg_sum;
   int   heavy_count;   // Pawns, rooks and queens of both colours
   int   minor_count;   // Knights and bishops of both colours
   logic insufficient;

   always_comb
   begin
      piece_t sq;

      mg_sum = 0;
      eg_sum = 0;
      heavy_count = 0;
      minor_count = 0;
      for (int s = 0; s < SQUARE_COUNT; s++)
      begin
         sq = term.board[s * PIECE_WIDTH +: PIECE_WIDTH];
         if (|(sq & BLACK_BIT))
         begin
            mg_sum = mg_sum - PIECE_MG[sq[2:0]];
            eg_sum = eg_sum - PIECE_EG[sq[2:0]];
         end
         else
         begin
            mg_sum = mg_sum + PIECE_MG[sq[2:0]];
            eg_sum = eg_sum + PIECE_EG[sq[2:0]];
         end
         if (sq[2:0] == PAWN || sq[2:0] == ROOK || sq[2:0] == QUEEN)
            heavy_count = heavy_count + 1;
         if (sq[2:0] == KNIGHT || sq[2:0] == BISHOP)
            minor_count = minor_count + 1;
      end
      insufficient = (heavy_count == 0) && (minor_count <= 1);
   end

   // Results captured on the first cycle start is seen
   always_ff @(posedge clk)
   begin
      if (term.start && !term.valid)
      begin
         term.mg <= eval_t'(mg_sum);
         term.eg <= eval_t'(eg_sum);
         material <= mg_sum;
         insufficient_material <= insufficient;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         term.valid <= 1'b0;
      else
         term.valid <= term.start;   // Drops the cycle after start falls
   end

endmodule

// File: rtl/evaluate_pawns.sv
module evaluate_pawns
   import chess_pkg::*, eval_pkg::*;
(
   input  logic           clk,
   input  logic           reset,
   eval_term_if.evaluator term
);

   logic [3:0] white_on_file [8];
   logic [3:0] black_on_file [8];
   logic [2:0] file;
   logic       files_done;
   eval_t      acc_mg;
   eval_t      acc_eg;
   int         file_mg;
   int         file_eg;

   // Pawn counts per file from a board that is static while start is high
   always_comb
   begin
      piece_t sq;

      for (int f = 0; f < 8; f++)
      begin
         white_on_file[f] = '0;
         black_on_file[f] = '0;
         for (int r = 0; r < 8; r++)
         begin
            sq = term.board[(f + 8 * r) * PIECE_WIDTH +: PIECE_WIDTH];
            if (sq[2:0] == PAWN)
            begin
               if (|(sq & BLACK_BIT))
                  black_on_file[f] = black_on_file[f] + 4'd1;
               else
                  white_on_file[f] = white_on_file[f] + 4'd1;
            end
         end
      end
   end

   // Penalty of the current file as black minus white
   always_comb
   begin
      logic [3:0] w_here, b_here, w_near, b_near;
      int         doubled_net, isolated_net;

      w_here = white_on_file[file];
      b_here = black_on_file[file];
      w_near = ((file == 3'd0) ? 4'd0 : white_on_file[file - 3'd1])
             | ((file == 3'd7) ? 4'd0 : white_on_file[file + 3'd1]);
      b_near = ((file == 3'd0) ? 4'd0 : black_on_file[file - 3'd1])
             | ((file == 3'd7) ? 4'd0 : black_on_file[file + 3'd1]);
      doubled_net = ((b_here == 4'd0) ? 0 : int'(b_here) - 1)
                  - ((w_here == 4'd0) ? 0 : int'(w_here) - 1);
      isolated_net = ((b_near == 4'd0) ? int'(b_here) : 0)
                   - ((w_near == 4'd0) ? int'(w_here) : 0);
      file_mg = doubled_net * DOUBLED_MG + isolated_net * ISOLATED_MG;
      file_eg = doubled_net * DOUBLED_EG + isolated_net * ISOLATED_EG;
   end

   always_ff @(posedge clk)
   begin
      if (reset || !term.start)
      begin
         file <= '0;
         files_done <= 1'b0;
         acc_mg <= '0;
         acc_eg <= '0;
         term.valid <= 1'b0;
      end
      else if (!files_done)
      begin
         acc_mg <= acc_mg + eval_t'(file_mg);
         acc_eg <= acc_eg + eval_t'(file_eg);
         file <= file + 3'd1;
         files_done <= (file == 3'd7);
      end
      else
         term.valid <= 1'b1;   // Sum cycle after file h
   end

   always_ff @(posedge clk)
   begin
      if (term.start && files_done && !term.valid)
      begin
         term.mg <= acc_mg;
         term.eg <= acc_eg;
      end
   end

endmodule

// File: rtl/popcount.sv
module popcount
   import chess_pkg::*;
(
   input  logic         clk,
   input  logic         reset,
   input  square_mask_t x0,
   output logic [6:0]   population
);

   logic [3:0] byte_count [8];
   logic [4:0] pair_count [4];
   logic [5:0] half_count [2];

   always_comb
   begin
      for (int b = 0; b < 8; b++)
      begin
         byte_count[b] = '0;
         for (int i = 0; i < 8; i++)
            byte_count[b] = byte_count[b] + 4'(x0[8 * b + i]);
      end
      for (int p = 0; p < 4; p++)
         pair_count[p] = 5'(byte_count[2 * p]) + 5'(byte_count[2 * p + 1]);
      for (int h = 0; h < 2; h++)
         half_count[h] = 6'(pair_count[2 * h]) + 6'(pair_count[2 * h + 1]);
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         population <= '0;
      else
         population <= 7'(half_count[0]) + 7'(half_count[1]);
   end

endmodule

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timescale 1ns/100ps -Wno-fatal \
   --top-module evaluate_tb -f list.f -o evaluate_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

output=$(./obj_dir/evaluate_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$output" | grep -qx "No errors"; then
   echo "PASS"
   exit 0
else
   echo "FAIL"
   exit 1
fi

// File: verification/evaluate_tb.sv
module evaluate_tb
   import chess_pkg::*, eval_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int WAIT_LIMIT = 200;
   localparam int PHASE_CAP = 62;
   localparam longint BLEND_DIVISOR = 1048576;
   localparam longint BLEND_SCALE = BLEND_DIVISOR / PHASE_CAP;

   // Piece values by type in the order empty, P, N, B, R, Q, K, unused
   localparam int MG_VALUE [8] = '{0, 82, 337, 365, 477, 1025, 0, 0};
   localparam int EG_VALUE [8] = '{0, 94, 281, 297, 512, 936, 0, 0};

   logic               clk;
   logic               reset;
   logic               board_valid;
   board_t             board_in;
   logic               clear_eval;
   eval_t              eval;
   logic               eval_valid;
   logic signed [31:0] material;
   logic               insufficient_material;

   int errors = 0;
   int checks = 0;

   evaluate UUT
   (
      .clk                   (clk),
      .reset                 (reset),
      .board_valid           (board_valid),
      .board_in              (board_in),
      .clear_eval            (clear_eval),
      .eval                  (eval),
      .eval_valid            (eval_valid),
      .material              (material),
      .insufficient_material (insufficient_material)
   );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic board_t put_piece(board_t b, int sq, piece_t p);
      b[4 * sq +: 4] = p;
      return b;
   endfunction

   // White counts positive and black negative
   function automatic int material_sum(board_t b, bit endgame);
      int     total;
      piece_t p;
      total = 0;
      for (int s = 0; s < 64; s++)
      begin
         p = b[4 * s +: 4];
         if (p[3])
            total -= endgame ? EG_VALUE[p[2:0]] : MG_VALUE[p[2:0]];
         else
            total += endgame ? EG_VALUE[p[2:0]] : MG_VALUE[p[2:0]];
      end
      return total;
   endfunction

   // Black penalties count for white and white penalties against
   function automatic int pawn_score(board_t b, bit endgame);
      int     count [2][8];   // Colour then file
      int     dbl;
      int     iso;
      int     n;
      int     near;
      int     score;
      piece_t p;
      dbl = endgame ? 56 : 11;
      iso = endgame ? 15 : 5;
      score = 0;
      for (int f = 0; f < 8; f++)
      begin
         count[0][f] = 0;
         count[1][f] = 0;
      end
      for (int s = 0; s < 64; s++)
      begin
         p = b[4 * s +: 4];
         if (p[2:0] == 3'd1)
            count[p[3]][s % 8]++;
      end
      for (int side = 0; side < 2; side++)
         for (int f = 0; f < 8; f++)
         begin
            n = count[side][f];
            near = ((f > 0) ? count[side][f - 1] : 0) + ((f < 7) ? count[side][f + 1] : 0);
            if (n > 1)
               score += (side == 1 ? 1 : -1) * (n - 1) * dbl;
            if (near == 0)
               score += (side == 1 ? 1 : -1) * n * iso;
         end
      return score;
   endfunction

   function automatic int game_phase(board_t b);
      int occupied;
      occupied = 0;
      for (int s = 0; s < 64; s++)
         if (b[4 * s +: 4] != 4'h0)
            occupied++;
      return (occupied > PHASE_CAP) ? PHASE_CAP : occupied;
   endfunction

   function automatic bit lacks_material(board_t b);
      int     heavy;
      int     minor;
      piece_t p;
      heavy = 0;
      minor = 0;
      for (int s = 0; s < 64; s++)
      begin
         p = b[4 * s +: 4];
         if (p[2:0] == 3'd1 || p[2:0] == 3'd4 || p[2:0] == 3'd5)
            heavy++;
         if (p[2:0] == 3'd2 || p[2:0] == 3'd3)
            minor++;
      end
      return (heavy == 0) && (minor <= 1);
   endfunction

   function automatic longint blended_eval(board_t b);
      longint             mg;
      longint             eg;
      longint             blend;
      longint             ph;
      logic signed [15:0] result;
      mg = longint'(material_sum(b, 1'b0) + pawn_score(b, 1'b0));
      eg = longint'(material_sum(b, 1'b1) + pawn_score(b, 1'b1));
      ph = longint'(game_phase(b));
      blend = mg * ph + eg * (PHASE_CAP - ph);
      blend = (blend * BLEND_SCALE) / BLEND_DIVISOR;   // Toward zero
      result = blend[15:0];
      return longint'(result);
   endfunction

   function automatic board_t start_position();
      board_t b;
      piece_t back [8] = '{4'h4, 4'h2, 4'h3, 4'h5, 4'h6, 4'h3, 4'h2, 4'h4};
      b = '0;
      for (int f = 0; f < 8; f++)
      begin
         b = put_piece(b, f, back[f]);
         b = put_piece(b, f + 8, 4'h1);
         b = put_piece(b, f + 48, 4'h9);
         b = put_piece(b, f + 56, back[f] | 4'h8);
      end
      return b;
   endfunction

   task automatic check_value(input string name, input longint actual, input longint expected);
      checks++;
      if (actual !== expected)
      begin
         errors++;
         $display("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected);
      end
   endtask

   // Scans forward from a random square to the first empty one
   task automatic place_random(inout board_t b, input piece_t p);
      int sq;
      sq = int'($urandom % 64);
      while (b[4 * sq +: 4] != 4'h0)
         sq = (sq + 1) % 64;
      b[4 * sq +: 4] = p;
   endtask

   task automatic random_board(output board_t b);
      piece_t kinds [10] = '{4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'h9, 4'hA, 4'hB, 4'hC, 4'hD};
      int     pieces;
      b = '0;
      place_random(b, 4'h6);
      place_random(b, 4'hE);
      pieces = 1 + int'($urandom % 10);   // Keeps sums inside 16 bits
      for (int i = 0; i < pieces; i++)
         place_random(b, kinds[$urandom % 10]);
   endtask

   task automatic start_eval(input board_t b);
      @(posedge clk);
      #1;
      board_in = b;
      board_valid = 1'b1;
      @(posedge clk);
      #1;
      board_valid = 1'b0;
   endtask

   task automatic evaluate_board(input board_t b, input string label);
      bit seen;
      seen = 1'b0;
      start_eval(b);
      for (int n = 0; n < WAIT_LIMIT && !seen; n++)
      begin
         @(posedge clk);
         #1;
         seen = eval_valid;
      end
      if (!seen)
      begin
         errors++;
         $display("Timeout: no result for %s within %0d cycles", label, WAIT_LIMIT);
      end
      else
      begin
         check_value({"eval (", label, ")"}, longint'(eval), blended_eval(b));
         check_value({"material (", label, ")"}, longint'(material),
                     longint'(material_sum(b, 1'b0)));
         check_value({"insufficient_material (", label, ")"},
                     longint'(insufficient_material), longint'(lacks_material(b)));
      end
   endtask

   task automatic clear_result();
      bit low;
      low = 1'b0;
      @(posedge clk);
      #1;
      clear_eval = 1'b1;
      @(posedge clk);
      #1;
      clear_eval = 1'b0;
      for (int n = 0; n < WAIT_LIMIT && !low; n++)
      begin
         low = !eval_valid;
         if (!low)
         begin
            @(posedge clk);
            #1;
         end
      end
      if (!low)
      begin
         errors++;
         $display("Timeout: eval_valid stayed high after clear_eval");
      end
   endtask

   // board_valid has been high since time zero
   task automatic held_level_ignored();
      bit rose;
      rose = 1'b0;
      check_value("eval_valid", longint'(eval_valid), 64'd0);
      for (int n = 0; n < WAIT_LIMIT && !rose; n++)
      begin
         @(posedge clk);
         #1;
         rose = eval_valid;
      end
      if (rose)
      begin
         errors++;
         $display("eval_valid rose without a rising edge on board_valid");
      end
      board_valid = 1'b0;
      @(posedge clk);
      #1;
   endtask

   task automatic start_position_is_even();
      evaluate_board(start_position(), "start position");
      check_value("eval (start position)", longint'(eval), 64'd0);
      check_value("material (start position)", longint'(material), 64'd0);
      clear_result();
   endtask

   task automatic score_random_boards();
      board_t b;
      for (int i = 0; i < 20; i++)
      begin
         random_board(b);
         evaluate_board(b, $sformatf("random board %0d", i));
         clear_result();
      end
   endtask

   task automatic score_pawn_structures();
      int     squares [4][4] = '{'{8, 16, -1, -1}, '{10, 12, -1, -1},
                                 '{11, 19, 27, 13}, '{9, 10, 18, -1}};
      board_t b;
      for (int c = 0; c < 4; c++)
      begin
         b = put_piece(put_piece('0, 4, 4'h6), 60, 4'hE);   // Kings on e1 and e8
         for (int i = 0; i < 4; i++)
            if (squares[c][i] >= 0)
               b = put_piece(b, squares[c][i], 4'h1);
         evaluate_board(b, $sformatf("pawn case %0d", c));
         clear_result();
      end
   endtask

   task automatic flag_insufficient_material();
      board_t kings;
      kings = put_piece(put_piece('0, 4, 4'h6), 60, 4'hE);
      evaluate_board(put_piece(kings, 27, 4'h2), "kings and knight");
      check_value("insufficient_material (kings and knight)",
                  longint'(insufficient_material), 64'd1);
      clear_result();
      evaluate_board(put_piece(kings, 12, 4'h1), "kings and pawn");
      check_value("insufficient_material (kings and pawn)",
                  longint'(insufficient_material), 64'd0);
      clear_result();
   endtask

   task automatic hold_then_clear();
      board_t first;
      board_t second;
      longint held;
      random_board(first);
      random_board(second);
      evaluate_board(first, "held board");
      held = blended_eval(first);
      for (int n = 0; n < 20; n++)
      begin
         @(posedge clk);
         #1;
         board_in = {8{$urandom}};   // Ignored while the board is frozen
         check_value("eval_valid (hold)", longint'(eval_valid), 64'd1);
         check_value("eval (hold)", longint'(eval), held);
      end
      clear_result();
      evaluate_board(second, "board after clear");
      clear_result();
   endtask

   initial
   begin
      void'($urandom(78));
      reset = 1'b1;
      board_valid = 1'b1;
      board_in = '0;
      clear_eval = 1'b0;
      repeat (8) @(posedge clk);
      #1;
      reset = 1'b0;

      held_level_ignored();
      start_position_is_even();
      score_random_boards();
      score_pawn_structures();
      flag_insufficient_material();
      hold_then_clear();

      $display("Checks: %0d, failures: %0d", checks, errors);
      if (errors == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

endmodule
